// File: conv_pkg.sv
package conv_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [4:0]  addr_t;
    typedef logic [19:0] acc_t;
    typedef logic [1:0]  coord_t;
    typedef logic [3:0]  tap_t;

    localparam int KERNEL_DIM  = 3;
    localparam int FEATURE_DIM = 4;
    localparam int OUT_DIM     = 2;
    localparam int NUM_PE      = 4;
    localparam int NUM_TAPS    = 9;
    localparam int MEM_WORDS   = 25;

    // weights first, then the feature map, both row-major
    localparam addr_t WEIGHT_BASE  = 5'd0;
    localparam addr_t FEATURE_BASE = 5'd9;

    localparam data_t DEFAULT_WEIGHTS [NUM_TAPS] = '{
        8'd1, 8'd2, 8'd3,
        8'd1, 8'd2, 8'd3,
        8'd1, 8'd2, 8'd3
    };

    localparam data_t DEFAULT_FEATURES [FEATURE_DIM*FEATURE_DIM] = '{
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4
    };

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WEIGHT_PRELOAD,
        S_FEATURE_STREAM,
        S_FLUSH
    } seq_state_t;

    typedef enum logic {
        D_IDLE,
        D_EMIT
    } drain_state_t;

    // counts the cycles inside one sequencer phase
    typedef logic [4:0] step_t;

    localparam int PRELOAD_CYCLES = 9;
    localparam int STREAM_CYCLES  = 16;

endpackage

// File: conv_scratchpad.sv
`timescale 1ns/100ps

module conv_scratchpad
    import conv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  busy,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  addr_t rd_addr,
    output data_t rd_data
);

    data_t mem [MEM_WORDS];

    // reset restores the default weights and feature map
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                mem[int'(WEIGHT_BASE) + i] <= DEFAULT_WEIGHTS[i];
            end
            for (int i = 0; i < FEATURE_DIM*FEATURE_DIM; i++) begin
                mem[int'(FEATURE_BASE) + i] <= DEFAULT_FEATURES[i];
            end
        end else begin
            // host port only while the engine is idle
            if (wr_en && !busy && (int'(wr_addr) < MEM_WORDS)) begin
                mem[wr_addr] <= wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: conv_sequencer.sv
`timescale 1ns/100ps

module conv_sequencer
    import conv_pkg::*;
    import ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   done,
    output addr_t  rd_addr,
    output logic   clear,
    output logic   weight_load,
    output tap_t   weight_tap,
    output logic   pix_valid,
    output coord_t pix_row,
    output coord_t pix_col,
    output logic   stream_end,
    output logic   busy
);

    seq_state_t state;
    step_t      step;
    logic       last_pix_d1;

    assign busy  = (state != S_IDLE);
    assign clear = (state == S_WEIGHT_PRELOAD) && (step == '0);

    always_comb begin
        rd_addr = WEIGHT_BASE;
        if (state == S_WEIGHT_PRELOAD) begin
            rd_addr = WEIGHT_BASE + addr_t'(step);
        end else if (state == S_FEATURE_STREAM) begin
            rd_addr = FEATURE_BASE + addr_t'(step);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_WEIGHT_PRELOAD;
                        step  <= '0;
                    end
                end
                S_WEIGHT_PRELOAD: begin
                    if (step == step_t'(PRELOAD_CYCLES - 1)) begin
                        state <= S_FEATURE_STREAM;
                        step  <= '0;
                    end else begin
                        step <= step + step_t'(1);
                    end
                end
                S_FEATURE_STREAM: begin
                    if (step == step_t'(STREAM_CYCLES - 1)) begin
                        state <= S_FLUSH;
                        step  <= '0;
                    end else begin
                        step <= step + step_t'(1);
                    end
                end
                // results are still draining
                S_FLUSH: begin
                    if (done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // strobes trail the address by one cycle to meet rd_data
    always_ff @(posedge clk) begin
        if (!rst) begin
            weight_load <= 1'b0;
            pix_valid   <= 1'b0;
            last_pix_d1 <= 1'b0;
            stream_end  <= 1'b0;
        end else begin
            weight_load <= (state == S_WEIGHT_PRELOAD);
            pix_valid   <= (state == S_FEATURE_STREAM);
            last_pix_d1 <= (state == S_FEATURE_STREAM) && (step == step_t'(STREAM_CYCLES - 1));
            // one more cycle for the MAC register
            stream_end  <= last_pix_d1;
        end
    end

    always_ff @(posedge clk) begin
        weight_tap <= tap_t'(step);
        pix_row    <= step[3:2];
        pix_col    <= step[1:0];
    end

endmodule

// File: conv_pe.sv
`timescale 1ns/100ps

module conv_pe
    import conv_pkg::*;
#(
    parameter coord_t PE_ROW = 2'd0,
    parameter coord_t PE_COL = 2'd0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,
    input  logic   weight_load,
    input  tap_t   weight_tap,
    input  logic   pix_valid,
    input  coord_t pix_row,
    input  coord_t pix_col,
    input  data_t  rd_data,
    output acc_t   acc
);

    data_t weights [NUM_TAPS];
    int    row_off;
    int    col_off;
    logic  in_window;
    tap_t  tap_sel;
    acc_t  product;

    always_ff @(posedge clk) begin
        if (weight_load) begin
            weights[weight_tap] <= rd_data;
        end
    end

    // pixel offset from this output position picks the weight
    always_comb begin
        row_off   = int'(pix_row) - int'(PE_ROW);
        col_off   = int'(pix_col) - int'(PE_COL);
        in_window = (row_off >= 0) && (row_off < KERNEL_DIM) &&
                    (col_off >= 0) && (col_off < KERNEL_DIM);
        tap_sel   = tap_t'(row_off * KERNEL_DIM + col_off);
        product   = '0;
        if (in_window) begin
            product = acc_t'(rd_data) * acc_t'(weights[tap_sel]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (pix_valid && in_window) begin
            acc <= acc + product;
        end
    end

endmodule

// File: conv_result_drain.sv
`timescale 1ns/100ps

module conv_result_drain
    import conv_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stream_end,
    input  acc_t       acc_0,
    input  acc_t       acc_1,
    input  acc_t       acc_2,
    input  acc_t       acc_3,
    output logic       res_valid,
    output logic [1:0] res_idx,
    output acc_t       res_data,
    output logic       done
);

    drain_state_t state;
    logic [1:0]   idx;
    acc_t         snap [NUM_PE];

    assign res_valid = (state == D_EMIT);
    assign res_idx   = idx;
    assign res_data  = snap[idx];

    // snapshot so the PEs are free for the next run
    always_ff @(posedge clk) begin
        if (state == D_IDLE && stream_end) begin
            snap[0] <= acc_0;
            snap[1] <= acc_1;
            snap[2] <= acc_2;
            snap[3] <= acc_3;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= D_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (stream_end) begin
                        state <= D_EMIT;
                        idx   <= '0;
                    end
                end
                D_EMIT: begin
                    if (idx == 2'(NUM_PE - 1)) begin
                        state <= D_IDLE;
                        done  <= 1'b1;
                    end else begin
                        idx <= idx + 2'd1;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

endmodule

// File: conv_top.sv
`timescale 1ns/100ps

module conv_top
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    output logic       busy,
    output logic       res_valid,
    output logic [1:0] res_idx,
    output acc_t       res_data,
    output logic       done
);

    addr_t  rd_addr;
    data_t  rd_data;
    logic   clear;
    logic   weight_load;
    tap_t   weight_tap;
    logic   pix_valid;
    coord_t pix_row;
    coord_t pix_col;
    logic   stream_end;
    acc_t   pe_acc [NUM_PE];

    conv_scratchpad conv_scratchpad_i (
        .clk     (clk),
        .rst     (rst),
        .busy    (busy),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    conv_sequencer conv_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .done        (done),
        .rd_addr     (rd_addr),
        .clear       (clear),
        .weight_load (weight_load),
        .weight_tap  (weight_tap),
        .pix_valid   (pix_valid),
        .pix_row     (pix_row),
        .pix_col     (pix_col),
        .stream_end  (stream_end),
        .busy        (busy)
    );

    // one PE per output position, index is row*2 + col
    for (genvar r = 0; r < OUT_DIM; r++) begin : g_row
        for (genvar c = 0; c < OUT_DIM; c++) begin : g_col
            conv_pe #(
                .PE_ROW (coord_t'(r)),
                .PE_COL (coord_t'(c))
            ) conv_pe_i (
                .clk         (clk),
                .rst         (rst),
                .clear       (clear),
                .weight_load (weight_load),
                .weight_tap  (weight_tap),
                .pix_valid   (pix_valid),
                .pix_row     (pix_row),
                .pix_col     (pix_col),
                .rd_data     (rd_data),
                .acc         (pe_acc[r*OUT_DIM + c])
            );
        end
    end

    conv_result_drain conv_result_drain_i (
        .clk        (clk),
        .rst        (rst),
        .stream_end (stream_end),
        .acc_0      (pe_acc[0]),
        .acc_1      (pe_acc[1]),
        .acc_2      (pe_acc[2]),
        .acc_3      (pe_acc[3]),
        .res_valid  (res_valid),
        .res_idx    (res_idx),
        .res_data   (res_data),
        .done       (done)
    );

endmodule

// File: conv_assert.sv
`timescale 1ns/100ps

module conv_assert (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       res_valid,
    input logic [1:0] res_idx,
    input logic       done
);

    a_valid_busy: assert property (
        @(posedge clk) disable iff (!rst)
        res_valid |-> busy
    ) else $error("res_valid high while the engine is idle");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst)
        done |=> !done
    ) else $error("done held for more than one cycle");

    // burst walks 0..3 on consecutive cycles
    a_idx_step: assert property (
        @(posedge clk) disable iff (!rst)
        (res_valid && res_idx != 2'd3) |=> (res_valid && res_idx == $past(res_idx) + 2'd1)
    ) else $error("res_idx did not advance by one inside a burst");

endmodule

bind conv_top conv_assert conv_assert_i (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .res_valid (res_valid),
    .res_idx   (res_idx),
    .done      (done)
);

// File: tb_conv_top.sv
`timescale 1ns/100ps

module tb_conv_top
    import conv_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_CYCLES  = 5;
    localparam int NUM_RUNS      = 6;
    localparam int RUN_CYCLES    = 60;
    localparam int MARGIN_CYCLES = 200;

    logic       clk;
    logic       rst;
    logic       start;
    logic       wr_en;
    addr_t      wr_addr;
    data_t      wr_data;
    logic       busy;
    logic       res_valid;
    logic [1:0] res_idx;
    acc_t       res_data;
    logic       done;

    data_t shadow [MEM_WORDS];
    int    exp_q [$];
    int    seed;
    int    burst_idx;
    int    result_count;
    int    done_count;

    conv_top conv_top_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .busy      (busy),
        .res_valid (res_valid),
        .res_idx   (res_idx),
        .res_data  (res_data),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input int got, input int expected);
        if (got != expected) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                                     $time, name, got, expected));
        end
    endtask

    function automatic data_t mem_word(input int addr);
        return shadow[addr_t'(addr)];
    endfunction

    // sum over the 3x3 window at output (row, col)
    function automatic int expected_result(input int idx);
        int row;
        int col;
        int sum;
        row = idx / OUT_DIM;
        col = idx % OUT_DIM;
        sum = 0;
        for (int i = 0; i < KERNEL_DIM; i++) begin
            for (int j = 0; j < KERNEL_DIM; j++) begin
                sum += int'(mem_word(int'(FEATURE_BASE) + (row + i) * FEATURE_DIM + col + j))
                     * int'(mem_word(int'(WEIGHT_BASE) + i * KERNEL_DIM + j));
            end
        end
        return sum;
    endfunction

    task automatic load_default_shadow;
        for (int i = 0; i < NUM_TAPS; i++) begin
            shadow[addr_t'(int'(WEIGHT_BASE) + i)] = DEFAULT_WEIGHTS[tap_t'(i)];
        end
        for (int i = 0; i < FEATURE_DIM * FEATURE_DIM; i++) begin
            shadow[addr_t'(int'(FEATURE_BASE) + i)] = DEFAULT_FEATURES[4'(i)];
        end
    endtask

    // shadow follows only the writes the engine should accept
    task automatic write_word(input addr_t addr, input data_t data, input bit track);
        @(posedge clk);
        #(DRIVE_DELAY);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        if (track) begin
            shadow[addr] = data;
        end
    endtask

    task automatic release_bus;
        @(posedge clk);
        #(DRIVE_DELAY);
        wr_en = 1'b0;
    endtask

    task automatic pulse_start;
        @(posedge clk);
        #(DRIVE_DELAY);
        start = 1'b1;
        @(posedge clk);
        #(DRIVE_DELAY);
        start = 1'b0;
    endtask

    task automatic load_random;
        for (int a = 0; a < MEM_WORDS; a++) begin
            write_word(addr_t'(a), data_t'($random(seed)), 1'b1);
        end
        release_bus();
    endtask

    task automatic run_once(input bit disturb);
        addr_t poke_addr;
        for (int i = 0; i < NUM_PE; i++) begin
            exp_q.push_back(expected_result(i));
        end
        pulse_start();
        @(negedge clk);
        compare("busy", int'(busy), 1);
        if (disturb) begin
            // center weight, inverted so a leak shows up
            poke_addr = addr_t'(int'(WEIGHT_BASE) + 4);
            write_word(poke_addr, ~shadow[poke_addr], 1'b0);
            release_bus();
            pulse_start();
        end
        while (!done) begin
            @(negedge clk);
            compare("busy", int'(busy), 1);
        end
        @(negedge clk);
        compare("busy", int'(busy), 0);
    endtask

    // result monitor
    initial begin
        int expected;
        burst_idx    = 0;
        result_count = 0;
        done_count   = 0;
        forever begin
            @(negedge clk);
            if (done) begin
                if (burst_idx != NUM_PE) begin
                    report_failure("done pulsed before all four results were seen");
                end
                burst_idx = 0;
                done_count++;
            end else if (burst_idx == NUM_PE) begin
                report_failure("done did not follow the last result");
            end
            if (res_valid) begin
                if (!busy) begin
                    report_failure("result strobe seen while the engine was idle");
                end
                if (exp_q.size() == 0) begin
                    report_failure("result strobe seen with no run pending");
                end
                expected = exp_q.pop_front();
                compare("res_idx", int'(res_idx), burst_idx);
                compare("res_data", int'(res_data), expected);
                burst_idx++;
                result_count++;
            end else if (burst_idx > 0) begin
                report_failure("result burst stopped before index 3");
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RUN_CYCLES * NUM_RUNS + MARGIN_CYCLES));
        report_failure("simulation timed out waiting for the engine to finish");
    end

    initial begin
        seed    = 70;
        rst     = 1'b0;
        start   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        load_default_shadow();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b1;

        // defaults give 42 in column 0 and 60 in column 1
        for (int i = 0; i < NUM_PE; i++) begin
            compare("reference on defaults", expected_result(i), (i % OUT_DIM == 0) ? 42 : 60);
        end
        run_once(1'b0);

        for (int r = 2; r < NUM_RUNS; r++) begin
            load_random();
            run_once(1'b1);
        end

        // same data again, the write during the last run must not stick
        run_once(1'b0);

        @(negedge clk);
        if (result_count == NUM_PE * NUM_RUNS && done_count == NUM_RUNS
                && exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure($sformatf("expected %0d results and %0d done pulses, saw %0d and %0d",
                                     NUM_PE * NUM_RUNS, NUM_RUNS, result_count, done_count));
        end
    end

endmodule

// File: project.f
conv_pkg.sv
ctrl_pkg.sv
conv_scratchpad.sv
conv_sequencer.sv
conv_pe.sv
conv_result_drain.sv
conv_top.sv
conv_assert.sv
tb_conv_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_conv_top -o sim_conv

./obj_dir/sim_conv | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
